//--- logic/silver_defs.svh
`ifndef SILVER_DEFS_SVH
`define SILVER_DEFS_SVH

// datapath widths
`define WORD_W       32
`define REG_ADDR_W   6
`define NUM_REGS     64
`define FUNC_W       4
`define OPC_W        6

// immediate and constant widths
`define SHORT_IMM_W  6
`define CONST_W      23   // LoadConstant magnitude, sign sits just above it
`define UPPER_W      9
`define UPPER_LSB    23

// instruction field positions
`define LONG_BIT     31   // set for LoadConstant
`define CLASS_BIT    24   // constant loads
`define IMM_A_BIT    23
`define IMM_B_BIT    16
`define RD_LSB       25
`define RA_LSB       17
`define RB_LSB       10
`define FUNC_LSB     6

`endif

//--- logic/silver_pkg.sv
`include "silver_defs.svh"

package silver_pkg;

   typedef enum logic [2:0] {
      op_normal,
      op_shift,
      op_load_const,
      op_load_upper,
      op_invalid
   } op_class_e;

   // ALU function encoding follows the instruction's function field
   typedef enum logic [`FUNC_W-1:0] {
      alu_add,
      alu_add_carry,
      alu_sub,
      alu_carry,
      alu_overflow,
      alu_inc,
      alu_dec,
      alu_mul,
      alu_mulhu,
      alu_and,
      alu_or,
      alu_xor,
      alu_equal,
      alu_less,
      alu_lower,
      alu_snd
   } alu_func_e;

   typedef enum logic [1:0] {
      shift_ll,
      shift_lr,
      shift_ar,
      shift_ror
   } shift_func_e;

   typedef struct packed {
      op_class_e               cls;
      logic [`FUNC_W-1:0]      func;
      logic [`REG_ADDR_W-1:0]  rd;
      logic [`REG_ADDR_W-1:0]  ra;
      logic [`REG_ADDR_W-1:0]  rb;
      logic                    use_imm_a;
      logic                    use_imm_b;
      logic [`WORD_W-1:0]      imm_a;      // already sign-extended
      logic [`WORD_W-1:0]      imm_b;
      logic [`WORD_W-1:0]      const_word; // signed constant or upper value
   } decoded_t;

   typedef struct packed {
      logic [`REG_ADDR_W-1:0]  rd;
      logic [`WORD_W-1:0]      value;
      logic                    write;
   } result_t;

endpackage

//--- logic/pipe_stage.sv
module pipe_stage #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     up_valid,
   output logic     up_ready,
   input  payload_t up_data,
   output logic     down_valid,
   input  logic     down_ready,
   output payload_t down_data
);

   logic     full_q;
   payload_t data_q;

   // free slot, or the held item leaves this cycle
   assign up_ready   = !full_q || down_ready;
   assign down_valid = full_q;
   assign down_data  = data_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         full_q <= 1'b0;
      end else if (up_ready) begin
         full_q <= up_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (up_valid && up_ready) begin
         data_q <= up_data;
      end
   end

endmodule

//--- logic/instr_decode.sv
`include "silver_defs.svh"

module instr_decode
   import silver_pkg::*;
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               in_valid,
   output logic               in_ready,
   input  logic [`WORD_W-1:0] in_instr,
   output logic               dec_valid,
   input  logic               dec_ready,
   output decoded_t           dec
);

   logic               word_valid;
   logic               word_ready;
   logic [`WORD_W-1:0] word;
   logic [`WORD_W-1:0] magnitude;
   decoded_t           dec_next;

   pipe_stage #(.payload_t(logic [`WORD_W-1:0])) u_word_stage (
      .clk        (clk),
      .arst_n     (arst_n),
      .up_valid   (in_valid),
      .up_ready   (in_ready),
      .up_data    (in_instr),
      .down_valid (word_valid),
      .down_ready (word_ready),
      .down_data  (word)
   );

   assign magnitude = {{(`WORD_W-`CONST_W){1'b0}}, word[`CONST_W-1:0]};

   always_comb begin
      dec_next.rd        = word[`RD_LSB +: `REG_ADDR_W];
      dec_next.ra        = word[`RA_LSB +: `REG_ADDR_W];
      dec_next.rb        = word[`RB_LSB +: `REG_ADDR_W];
      dec_next.use_imm_a = word[`IMM_A_BIT];
      dec_next.use_imm_b = word[`IMM_B_BIT];
      // short immediates reuse the ra / rb fields
      dec_next.imm_a = {{(`WORD_W-`SHORT_IMM_W){word[`RA_LSB+`SHORT_IMM_W-1]}},
                        word[`RA_LSB +: `SHORT_IMM_W]};
      dec_next.imm_b = {{(`WORD_W-`SHORT_IMM_W){word[`RB_LSB+`SHORT_IMM_W-1]}},
                        word[`RB_LSB +: `SHORT_IMM_W]};
      dec_next.func       = '0;
      dec_next.const_word = '0;

      if (word[`CLASS_BIT]) begin
         if (word[`LONG_BIT]) begin
            dec_next.cls        = op_load_const;
            dec_next.const_word = word[`CONST_W] ? -magnitude : magnitude; // sign bit above
         end else if (word[`UPPER_LSB:`UPPER_W] == '0) begin
            dec_next.cls        = op_load_upper;
            dec_next.const_word = {{(`WORD_W-`UPPER_W){1'b0}}, word[`UPPER_W-1:0]};
         end else begin
            dec_next.cls = op_invalid;
         end
      end else if (!word[`LONG_BIT] && word[`OPC_W-1:0] == 'd0) begin
         dec_next.cls  = op_normal;
         dec_next.func = word[`FUNC_LSB +: `FUNC_W];
      end else if (!word[`LONG_BIT] && word[`OPC_W-1:0] == 'd1) begin
         dec_next.cls  = op_shift;
         dec_next.func = word[`FUNC_LSB +: `FUNC_W];
      end else begin
         dec_next.cls = op_invalid;
      end
   end

   pipe_stage #(.payload_t(decoded_t)) u_dec_stage (
      .clk        (clk),
      .arst_n     (arst_n),
      .up_valid   (word_valid),
      .up_ready   (word_ready),
      .up_data    (dec_next),
      .down_valid (dec_valid),
      .down_ready (dec_ready),
      .down_data  (dec)
   );

endmodule

//--- logic/alu_execute.sv
`include "silver_defs.svh"

module alu_execute
   import silver_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   dec_valid,
   output logic                   dec_ready,
   input  decoded_t               dec,
   output logic [`REG_ADDR_W-1:0] ra_addr,
   output logic [`REG_ADDR_W-1:0] rb_addr,
   output logic [`REG_ADDR_W-1:0] rd_addr,
   input  logic [`WORD_W-1:0]     ra_data,
   input  logic [`WORD_W-1:0]     rb_data,
   input  logic [`WORD_W-1:0]     rd_data,
   input  result_t                fwd,
   input  logic                   fwd_valid,
   output logic                   res_valid,
   input  logic                   res_ready,
   output result_t                res
);

   logic [`WORD_W-1:0]   a_val;
   logic [`WORD_W-1:0]   b_val;
   logic [`WORD_W-1:0]   d_val;
   logic [`WORD_W:0]     sum;
   logic [`WORD_W-1:0]   diff;
   logic [2*`WORD_W-1:0] prod;
   logic [2*`WORD_W-1:0] rot_pair;
   logic [`WORD_W-1:0]   alu_res;
   logic [`WORD_W-1:0]   shift_res;
   logic                 carry_q;
   logic                 ovf_q;
   logic                 carry_nx;
   logic                 ovf_nx;
   alu_func_e            alu_fn;
   shift_func_e          sh_fn;

   // the held writeback item is the only result not yet in the register file
   function automatic logic [`WORD_W-1:0] fwd_pick(input result_t held, input logic held_vld,
                                                  input logic [`REG_ADDR_W-1:0] addr,
                                                  input logic [`WORD_W-1:0] rf_word);
      fwd_pick = (held_vld && held.write && held.rd == addr) ? held.value : rf_word;
   endfunction

   assign ra_addr = dec.ra;
   assign rb_addr = dec.rb;
   assign rd_addr = dec.rd;

   assign a_val = dec.use_imm_a ? dec.imm_a : fwd_pick(fwd, fwd_valid, dec.ra, ra_data);
   assign b_val = dec.use_imm_b ? dec.imm_b : fwd_pick(fwd, fwd_valid, dec.rb, rb_data);
   assign d_val = fwd_pick(fwd, fwd_valid, dec.rd, rd_data); // for upper merge

   assign alu_fn = alu_func_e'(dec.func);
   assign sh_fn  = shift_func_e'(dec.func[1:0]);

   assign sum  = {1'b0, a_val} + {1'b0, b_val}
               + {{`WORD_W{1'b0}}, (alu_fn == alu_add_carry) && carry_q};
   assign diff = a_val - b_val;
   assign prod = {{`WORD_W{1'b0}}, a_val} * {{`WORD_W{1'b0}}, b_val};
   assign rot_pair = {a_val, a_val} >> b_val[$clog2(`WORD_W)-1:0];

   always_comb begin
      carry_nx = carry_q;
      ovf_nx   = ovf_q;
      case (alu_fn)
         alu_add: begin
            alu_res  = sum[`WORD_W-1:0];
            carry_nx = sum[`WORD_W];
            ovf_nx   = (a_val[`WORD_W-1] == b_val[`WORD_W-1]) &&
                       (sum[`WORD_W-1] != a_val[`WORD_W-1]);
         end
         alu_add_carry: begin
            alu_res  = sum[`WORD_W-1:0];
            carry_nx = sum[`WORD_W];
         end
         alu_sub: begin
            alu_res = diff;
            ovf_nx  = (a_val[`WORD_W-1] != b_val[`WORD_W-1]) &&
                      (diff[`WORD_W-1] != a_val[`WORD_W-1]);
         end
         alu_carry:    alu_res = {{(`WORD_W-1){1'b0}}, carry_q};
         alu_overflow: alu_res = {{(`WORD_W-1){1'b0}}, ovf_q};
         alu_inc:      alu_res = a_val + 1'b1;
         alu_dec:      alu_res = a_val - 1'b1;
         alu_mul:      alu_res = prod[`WORD_W-1:0];
         alu_mulhu:    alu_res = prod[2*`WORD_W-1:`WORD_W];
         alu_and:      alu_res = a_val & b_val;
         alu_or:       alu_res = a_val | b_val;
         alu_xor:      alu_res = a_val ^ b_val;
         alu_equal:    alu_res = {{(`WORD_W-1){1'b0}}, a_val == b_val};
         alu_less:     alu_res = {{(`WORD_W-1){1'b0}}, $signed(a_val) < $signed(b_val)};
         alu_lower:    alu_res = {{(`WORD_W-1){1'b0}}, a_val < b_val};
         default:      alu_res = b_val; // snd
      endcase
   end

   always_comb begin
      case (sh_fn)
         shift_ll: shift_res = a_val << b_val;   // full B, 32 and up clears
         shift_lr: shift_res = a_val >> b_val;
         shift_ar: shift_res = $signed(a_val) >>> b_val;
         default:  shift_res = rot_pair[`WORD_W-1:0];
      endcase
   end

   always_comb begin
      res.rd    = dec.rd;
      res.write = 1'b1;
      case (dec.cls)
         op_normal:     res.value = alu_res;
         op_shift:      res.value = shift_res;
         op_load_const: res.value = dec.const_word;
         op_load_upper: res.value = {dec.const_word[`UPPER_W-1:0], d_val[`UPPER_LSB-1:0]};
         default: begin
            res.value = '0;
            res.write = 1'b0;
         end
      endcase
   end

   assign res_valid = dec_valid;
   assign dec_ready = res_ready;

   // flags move only with the item going into writeback
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         carry_q <= 1'b0;
         ovf_q   <= 1'b0;
      end else if (res_valid && res_ready && dec.cls == op_normal) begin
         carry_q <= carry_nx;
         ovf_q   <= ovf_nx;
      end
   end

endmodule

//--- logic/writeback_unit.sv
`include "silver_defs.svh"

module writeback_unit
   import silver_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   res_valid,
   output logic                   res_ready,
   input  result_t                res,
   input  logic [`REG_ADDR_W-1:0] ra_addr,
   input  logic [`REG_ADDR_W-1:0] rb_addr,
   input  logic [`REG_ADDR_W-1:0] rd_addr,
   output logic [`WORD_W-1:0]     ra_data,
   output logic [`WORD_W-1:0]     rb_data,
   output logic [`WORD_W-1:0]     rd_data,
   output result_t                fwd,
   output logic                   fwd_valid,
   output logic                   out_valid,
   input  logic                   out_ready,
   output result_t                out_result
);

   logic [`WORD_W-1:0] regs [`NUM_REGS];
   logic               wr_en;

   pipe_stage #(.payload_t(result_t)) u_res_stage (
      .clk        (clk),
      .arst_n     (arst_n),
      .up_valid   (res_valid),
      .up_ready   (res_ready),
      .up_data    (res),
      .down_valid (out_valid),
      .down_ready (out_ready),
      .down_data  (out_result)
   );

   // held result is visible to execute until it is written
   assign fwd       = out_result;
   assign fwd_valid = out_valid;

   assign ra_data = regs[ra_addr];
   assign rb_data = regs[rb_addr];
   assign rd_data = regs[rd_addr];

   // commit on acceptance at the output
   assign wr_en = out_valid && out_ready && out_result.write;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[out_result.rd] <= out_result.value;
      end
   end

endmodule

//--- logic/silver_core.sv
`include "silver_defs.svh"

module silver_core
   import silver_pkg::*;
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               in_valid,
   output logic               in_ready,
   input  logic [`WORD_W-1:0] in_instr,
   output logic               out_valid,
   input  logic               out_ready,
   output result_t            out_result
);

   logic                   dec_valid;
   logic                   dec_ready;
   decoded_t               dec;
   logic                   res_valid;
   logic                   res_ready;
   result_t                res;
   logic [`REG_ADDR_W-1:0] ra_addr;
   logic [`REG_ADDR_W-1:0] rb_addr;
   logic [`REG_ADDR_W-1:0] rd_addr;
   logic [`WORD_W-1:0]     ra_data;
   logic [`WORD_W-1:0]     rb_data;
   logic [`WORD_W-1:0]     rd_data;
   result_t                fwd;
   logic                   fwd_valid;

   instr_decode u_decode (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_instr  (in_instr),
      .dec_valid (dec_valid),
      .dec_ready (dec_ready),
      .dec       (dec)
   );

   alu_execute u_execute (
      .clk       (clk),
      .arst_n    (arst_n),
      .dec_valid (dec_valid),
      .dec_ready (dec_ready),
      .dec       (dec),
      .ra_addr   (ra_addr),
      .rb_addr   (rb_addr),
      .rd_addr   (rd_addr),
      .ra_data   (ra_data),
      .rb_data   (rb_data),
      .rd_data   (rd_data),
      .fwd       (fwd),
      .fwd_valid (fwd_valid),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res       (res)
   );

   writeback_unit u_writeback (
      .clk        (clk),
      .arst_n     (arst_n),
      .res_valid  (res_valid),
      .res_ready  (res_ready),
      .res        (res),
      .ra_addr    (ra_addr),
      .rb_addr    (rb_addr),
      .rd_addr    (rd_addr),
      .ra_data    (ra_data),
      .rb_data    (rb_data),
      .rd_data    (rd_data),
      .fwd        (fwd),
      .fwd_valid  (fwd_valid),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_result (out_result)
   );

endmodule

//--- verification/clock_gen.sv
module clock_gen #(
   parameter int PERIOD       = 10,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 arst_n = 1'b1;   // release just after the edge
   end

endmodule

//--- verification/silver_core_tb.sv
`include "silver_defs.svh"

module silver_core_tb
   import silver_pkg::*;
();

   localparam int RESET_CYCLES = 8;
   localparam int DRIVE_DLY    = 1;   // after the rising edge
   localparam int DRAIN_CYCLES = 6;

   // one table row holds an instruction and the result it must produce
   typedef struct packed {
      logic [`WORD_W-1:0]     instr;
      logic [`REG_ADDR_W-1:0] rd;
      logic [`WORD_W-1:0]     value;
      logic                   write;
   } check_t;

   logic               clk;
   logic               arst_n;
   logic               in_valid;
   logic               in_ready;
   logic [`WORD_W-1:0] in_instr;
   logic               out_valid;
   logic               out_ready;
   result_t            out_result;

   check_t tests[$];
   int     seed = 32'h3ca8_1ab8;
   int     n_out;
   int     cycles;
   int     cycle_limit;
   int     mismatches;
   int     other_errors;

   clock_gen #(.PERIOD(10), .RESET_CYCLES(RESET_CYCLES)) u_clock (
      .clk    (clk),
      .arst_n (arst_n)
   );

   silver_core UUT (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_instr   (in_instr),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_result (out_result)
   );

   // register form with an immediate flag then a field for A and for B
   function automatic logic [`WORD_W-1:0] alu_op(input logic [3:0] fn, input logic [5:0] rd,
         input logic ia, input logic [5:0] ra, input logic ib, input logic [5:0] rb);
      alu_op = {1'b0, rd, 1'b0, ia, ra, ib, rb, fn, 6'd0};
   endfunction

   function automatic logic [`WORD_W-1:0] shift_op(input logic [1:0] fn, input logic [5:0] rd,
         input logic ia, input logic [5:0] ra, input logic ib, input logic [5:0] rb);
      shift_op = {1'b0, rd, 1'b0, ia, ra, ib, rb, 2'b00, fn, 6'd1};
   endfunction

   function automatic logic [`WORD_W-1:0] const_op(input logic [5:0] rd, input logic neg,
                                                   input logic [22:0] mag);
      const_op = {1'b1, rd, 1'b1, neg, mag};
   endfunction

   function automatic logic [`WORD_W-1:0] upper_op(input logic [5:0] rd, input logic [8:0] val);
      upper_op = {1'b0, rd, 1'b1, 15'd0, val};
   endfunction

   function automatic void add_test(input logic [`WORD_W-1:0] instr, input logic [5:0] rd,
                                    input logic [`WORD_W-1:0] value, input logic write);
      tests.push_back(check_t'{instr, rd, value, write});
   endfunction

   function automatic void build_table();
      // constant loads then an upper load that keeps the low 23 bits
      add_test(const_op(1, 0, 23'h012345), 1, 32'h0001_2345, 1);
      add_test(const_op(2, 1, 23'd5), 2, 32'hffff_fffb, 1);
      add_test(upper_op(1, 9'h1a5), 1, 32'hd281_2345, 1);
      add_test(const_op(3, 0, 23'd7), 3, 32'd7, 1);
      add_test(const_op(4, 1, 23'd3), 4, 32'hffff_fffd, 1);
      // alu on registers and short immediates
      add_test(alu_op(alu_add, 5, 0, 3, 1, 9), 5, 32'd16, 1);
      add_test(alu_op(alu_sub, 6, 0, 3, 0, 4), 6, 32'd10, 1);
      add_test(alu_op(alu_inc, 7, 0, 2, 0, 0), 7, 32'hffff_fffc, 1);
      add_test(alu_op(alu_dec, 8, 1, 6'h20, 0, 0), 8, 32'hffff_ffdf, 1);
      add_test(alu_op(alu_mul, 9, 0, 3, 0, 4), 9, 32'hffff_ffeb, 1);
      add_test(alu_op(alu_mulhu, 10, 0, 4, 0, 2), 10, 32'hffff_fff8, 1);
      add_test(alu_op(alu_and, 11, 0, 1, 1, 6'h1f), 11, 32'd5, 1);
      add_test(alu_op(alu_or, 12, 0, 1, 1, 6'h30), 12, 32'hffff_fff5, 1);
      add_test(alu_op(alu_xor, 13, 0, 1, 0, 2), 13, 32'h2d7e_dcbe, 1);
      add_test(alu_op(alu_equal, 14, 0, 3, 1, 7), 14, 32'd1, 1);
      add_test(alu_op(alu_equal, 15, 0, 3, 0, 4), 15, 32'd0, 1);
      add_test(alu_op(alu_less, 16, 0, 4, 0, 3), 16, 32'd1, 1);   // -3 < 7 signed
      add_test(alu_op(alu_lower, 17, 0, 4, 0, 3), 17, 32'd0, 1);
      add_test(alu_op(alu_snd, 18, 1, 6'h3f, 0, 1), 18, 32'hd281_2345, 1);
      // add sets both flags, addc clears carry and sub clears overflow
      add_test(upper_op(20, 9'h100), 20, 32'h8000_0000, 1);
      add_test(alu_op(alu_add, 21, 0, 20, 0, 20), 21, 32'd0, 1);
      add_test(alu_op(alu_carry, 22, 0, 0, 0, 0), 22, 32'd1, 1);
      add_test(alu_op(alu_overflow, 23, 0, 0, 0, 0), 23, 32'd1, 1);
      add_test(alu_op(alu_add_carry, 24, 0, 3, 0, 5), 24, 32'd24, 1);
      add_test(alu_op(alu_sub, 25, 0, 3, 0, 4), 25, 32'd10, 1);
      add_test(alu_op(alu_carry, 26, 0, 0, 0, 0), 26, 32'd0, 1);
      add_test(alu_op(alu_overflow, 27, 0, 0, 0, 0), 27, 32'd0, 1);
      // shifts with r32 holding 36
      add_test(shift_op(shift_ll, 28, 0, 3, 1, 4), 28, 32'h0000_0070, 1);
      add_test(shift_op(shift_lr, 29, 0, 1, 1, 8), 29, 32'h00d2_8123, 1);
      add_test(shift_op(shift_ar, 30, 0, 1, 1, 8), 30, 32'hffd2_8123, 1);
      add_test(const_op(32, 0, 23'd36), 32, 32'd36, 1);
      add_test(shift_op(shift_ll, 33, 0, 3, 0, 32), 33, 32'd0, 1);
      add_test(shift_op(shift_ar, 34, 0, 1, 0, 32), 34, 32'hffff_ffff, 1);
      add_test(shift_op(shift_lr, 35, 0, 1, 1, 6'h20), 35, 32'd0, 1);
      add_test(shift_op(shift_ror, 36, 0, 1, 0, 32), 36, 32'h5d28_1234, 1);
      add_test(shift_op(shift_ror, 37, 0, 3, 1, 1), 37, 32'h8000_0003, 1);
      // dependent chain where each reads the previous rd
      add_test(alu_op(alu_inc, 40, 0, 3, 0, 0), 40, 32'd8, 1);
      add_test(alu_op(alu_mul, 41, 0, 40, 0, 40), 41, 32'd64, 1);
      add_test(alu_op(alu_sub, 42, 0, 41, 1, 1), 42, 32'd63, 1);
      add_test(alu_op(alu_xor, 43, 0, 42, 1, 6'h3f), 43, 32'hffff_ffc0, 1);
      add_test(shift_op(shift_ar, 44, 0, 43, 1, 2), 44, 32'hffff_fff0, 1);
      add_test(alu_op(alu_add, 44, 0, 44, 0, 41), 44, 32'h0000_0030, 1);
      add_test(upper_op(44, 9'h003), 44, 32'h0180_0030, 1);
      add_test(alu_op(alu_dec, 45, 0, 44, 0, 0), 45, 32'h0180_002f, 1);
      // invalid words leave r45 alone
      add_test(upper_op(45, 9'h000) | 32'h0000_0200, 45, 32'd0, 0);
      add_test({1'b0, 6'd45, 25'd2}, 45, 32'd0, 0);
      add_test(alu_op(alu_snd, 46, 0, 0, 0, 45), 46, 32'h0180_002f, 1);
   endfunction

   task automatic check_row(input int idx);
      check_t exp;
      exp = tests[idx];
      assert (out_result.rd == exp.rd) else begin
         $display("FAILED at %0t: out_result.rd expected %0d, got %0d (row %0d)",
                  $time, exp.rd, out_result.rd, idx);
         mismatches++;
      end
      assert (out_result.write == exp.write) else begin
         $display("FAILED at %0t: out_result.write expected %b, got %b (row %0d)",
                  $time, exp.write, out_result.write, idx);
         mismatches++;
      end
      if (exp.write) begin
         assert (out_result.value == exp.value) else begin
            $display("FAILED at %0t: out_result.value expected %h, got %h (row %0d)",
                     $time, exp.value, out_result.value, idx);
            mismatches++;
         end
      end
   endtask

   task automatic drive_instrs();
      logic taken;
      @(posedge clk);
      #DRIVE_DLY;
      foreach (tests[i]) begin
         in_valid = 1'b1;
         in_instr = tests[i].instr;
         do begin
            @(negedge clk);
            taken = in_ready;   // stable by mid cycle
            @(posedge clk);
            #DRIVE_DLY;
         end while (!taken);
      end
      in_valid = 1'b0;
   endtask

   // random back-pressure with ready in about three of four cycles
   task automatic take_results();
      forever begin
         @(posedge clk);
         #DRIVE_DLY;
         out_ready = ($random(seed) & 3) != 0;
         @(negedge clk);
         if (out_valid && out_ready) begin
            assert (n_out < tests.size()) else begin
               $display("an extra result came out after all %0d expected ones", tests.size());
               other_errors++;
            end
            if (n_out < tests.size()) begin
               check_row(n_out);
            end
            n_out++;
         end
      end
   endtask

   initial begin
      in_valid     = 1'b0;
      in_instr     = '0;
      out_ready    = 1'b0;
      n_out        = 0;
      cycles       = 0;
      mismatches   = 0;
      other_errors = 0;
      build_table();
      cycle_limit = 8 * tests.size() + RESET_CYCLES;
      @(posedge arst_n);
      @(negedge clk);
      assert (out_valid == 1'b0) else begin
         $display("FAILED at %0t: out_valid expected 0, got %b", $time, out_valid);
         mismatches++;
      end
      assert (in_ready == 1'b1) else begin
         $display("FAILED at %0t: in_ready expected 1, got %b", $time, in_ready);
         mismatches++;
      end
      fork
         drive_instrs();
         take_results();
      join_none
      while (n_out < tests.size() && cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      if (n_out < tests.size()) begin
         $display("timeout: only %0d of %0d results arrived within %0d cycles",
                  n_out, tests.size(), cycle_limit);
         other_errors++;
      end else begin
         repeat (DRAIN_CYCLES) @(posedge clk);   // catch duplicates
      end
      $display("results %0d of %0d, value errors %0d, other errors %0d",
               n_out, tests.size(), mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- silver_core.f
+incdir+logic
logic/silver_pkg.sv
logic/pipe_stage.sv
logic/instr_decode.sv
logic/alu_execute.sv
logic/writeback_unit.sv
logic/silver_core.sv
verification/clock_gen.sv
verification/silver_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := silver_core_tb
FILELIST  := silver_core.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := >>> PASS
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
